// ==== bench/elink_loop_tb.sv ====
`timescale 1ns/1ps
`include "elink_config.svh"

module elink_loop_tb
   import elink_pkg::*;
();

   localparam int NUM_ENTRIES    = 16;
   localparam int PHASE4_FIRST   = 11;                // Stalled read burst starts here
   localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 60 + 200;
   localparam int LONG_WAIT      = 20;                // Beyond any unstalled rd_wait

   // One stimulus row
   typedef struct packed {
      logic        wr;                                // Write flag of the request
      logic [31:0] addr;                              // dstaddr
      logic [31:0] data;                              // Write data of write rows
      int          stall;                             // ext_rr_wait cycles for reads
   } tab_entry_t;

   logic          clkin = 1'b0;
   logic          reset = 1'b1;
   logic          ext_access = 1'b0;
   emesh_packet_t ext_packet = '0;
   logic          ext_rr_wait = 1'b1;                 // Host holds responses by default
   logic          rd_wait;
   logic          wr_wait;
   logic          dut_access;
   emesh_packet_t dut_packet;

   tab_entry_t    tab [NUM_ENTRIES];
   logic [31:0]   mem_model [2**`ELINK_MEM_AW];       // Mirror of the DUT memory
   emesh_packet_t exp_q [$];                          // Expected responses in issue order
   int            stall_q [$];                        // Stall length per response
   int            cycles = 0;
   int            stall_left = 0;
   int            n_resp = 0;
   logic          in_resp = 1'b0;                     // Current response seen already
   logic          taking = 1'b0;                      // Response leaves at next rise
   logic          long_wait_seen = 1'b0;              // rd_wait held by back-pressure

   elink_loop_top uut (
      .clkin       (clkin),
      .reset       (reset),
      .ext_access  (ext_access),
      .ext_packet  (ext_packet),
      .rd_wait     (rd_wait),
      .wr_wait     (wr_wait),
      .ext_rr_wait (ext_rr_wait),
      .dut_access  (dut_access),
      .dut_packet  (dut_packet)
   );

   always #4 clkin = ~clkin;                          // 8 ns period

   always @(posedge clkin) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles with %0d responses still missing",
                  cycles, exp_q.size());
         abort_run();
      end
   end

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_packet(input string name, input emesh_packet_t got,
                               input emesh_packet_t exp);
      if (got !== exp) begin
         $display("ERROR: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_access(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // Host request for one row with srcaddr tagged by row number
   function automatic emesh_packet_t make_request(input tab_entry_t e, input int idx);
      emesh_packet_t p;
      p.srcaddr  = 32'h8000_0000 | (32'(idx) << 8);
      p.data     = e.wr ? e.data : 32'h0;
      p.dstaddr  = e.addr;
      p.ctrlmode = idx[3:0];                          // Varies per row
      p.datamode = 2'b10;
      p.write    = e.wr;
      p.spare    = 1'b0;
      return p;
   endfunction

   // Response built from the request and the memory mirror
   function automatic emesh_packet_t expect_response(input emesh_packet_t req);
      emesh_packet_t r;
      r.srcaddr  = req.dstaddr;
      r.data     = mem_model[req.dstaddr[`ELINK_MEM_AW+1:2]];
      r.dstaddr  = req.srcaddr;
      r.ctrlmode = req.ctrlmode;
      r.datamode = req.datamode;
      r.write    = 1'b1;
      r.spare    = 1'b0;
      return r;
   endfunction

   task automatic set_entry(input int idx, input logic wr, input logic [31:0] addr,
                            input logic [31:0] data, input int stall);
      tab[idx] = '{wr, addr, data, stall};
   endtask

   task automatic load_table();
      set_entry(0,  1'b1, 32'h0000_0010, 32'hA5A5_0001, 0);   // Write then read back
      set_entry(1,  1'b0, 32'h0000_0010, 32'h0,         0);
      set_entry(2,  1'b1, 32'h0000_0020, 32'h1111_2222, 0);   // Several writes
      set_entry(3,  1'b1, 32'h0000_00A4, 32'h3333_4444, 0);
      set_entry(4,  1'b1, 32'h0000_03FC, 32'h5555_6666, 0);
      set_entry(5,  1'b1, 32'h0000_0020, 32'h7777_8888, 0);   // Overwrites row 2
      set_entry(6,  1'b0, 32'h0000_03FC, 32'h0,         2);   // Reads in another order
      set_entry(7,  1'b0, 32'h0000_0020, 32'h0,         0);
      set_entry(8,  1'b0, 32'h0000_00A4, 32'h0,         1);
      set_entry(9,  1'b1, 32'h0000_0100, 32'hDEAD_BEEF, 0);   // Back to back pair
      set_entry(10, 1'b0, 32'h0000_0100, 32'h0,         0);
      set_entry(11, 1'b0, 32'h0000_0010, 32'h0, 20 + int'($urandom % 21));
      set_entry(12, 1'b0, 32'h0000_00A4, 32'h0, 20 + int'($urandom % 21));
      set_entry(13, 1'b0, 32'h0000_0100, 32'h0, 20 + int'($urandom % 21));
      set_entry(14, 1'b0, 32'h0000_03FC, 32'h0, 20 + int'($urandom % 21));
      set_entry(15, 1'b0, 32'h0000_0020, 32'h0, 20 + int'($urandom % 21));
   endtask

   // Drive one row on falling edges once the lane wait is low
   task automatic issue_entry(input int idx);
      tab_entry_t    e;
      emesh_packet_t req;
      int            waited;
      e      = tab[idx];
      req    = make_request(e, idx);
      waited = 0;
      if (e.wr) begin
         while (exp_q.size() != 0)                    // Reads before a write stay older
            @(negedge clkin);
      end
      while ((e.wr ? wr_wait : rd_wait) == 1'b1) begin
         @(negedge clkin);
         waited++;
      end
      if (!e.wr && waited > LONG_WAIT)
         long_wait_seen = 1'b1;
      if (e.wr) begin
         mem_model[e.addr[`ELINK_MEM_AW+1:2]] = e.data;
      end else begin
         exp_q.push_back(expect_response(req));
         stall_q.push_back(e.stall);
      end
      ext_packet = req;
      ext_access = 1'b1;                              // Taken at the next rising edge
      @(negedge clkin);
      ext_access = 1'b0;
   endtask

   // Response side drives ext_rr_wait on falling edges
   always @(negedge clkin) begin
      if (!reset) begin
         if (taking) begin
            taking      = 1'b0;
            ext_rr_wait = 1'b1;
            check_access("dut_access after take", dut_access, 1'b0);   // No duplicate
         end else if (dut_access) begin
            if (exp_q.size() == 0) begin
               $display("A response arrived while no read was outstanding");
               abort_run();
            end else begin
               if (!in_resp) begin
                  in_resp    = 1'b1;
                  stall_left = stall_q[0];
               end
               if (stall_left > 0) begin
                  stall_left--;                       // Keep holding
               end else begin
                  check_packet("dut_packet", dut_packet, exp_q[0]);
                  void'(exp_q.pop_front());
                  void'(stall_q.pop_front());
                  in_resp     = 1'b0;
                  taking      = 1'b1;
                  ext_rr_wait = 1'b0;
                  n_resp++;
               end
            end
         end
      end
   end

   initial begin
      void'($urandom(32'h821acf40));
      load_table();
      repeat (16) @(negedge clkin);
      reset = 1'b0;
      @(negedge clkin);
      check_access("dut_access", dut_access, 1'b0);
      check_access("rd_wait", rd_wait, 1'b0);
      check_access("wr_wait", wr_wait, 1'b0);
      repeat (20) @(negedge clkin);                   // Idle stretch with no reads in flight
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         if (i == PHASE4_FIRST)
            long_wait_seen = 1'b0;
         issue_entry(i);
      end
      while (exp_q.size() != 0)
         @(negedge clkin);
      if (!long_wait_seen) begin
         $display("rd_wait never stayed high while responses were held back");
         abort_run();
      end
      repeat (40) @(negedge clkin);                   // Watch for stray responses
      check_access("dut_access", dut_access, 1'b0);
      $display("Responses checked: %0d", n_resp);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+include
src/elink_pkg.sv
src/lane_tx.sv
src/lane_rx.sv
src/emem_port.sv
src/elink_loop_top.sv
bench/elink_loop_tb.sv

// ==== include/elink_config.svh ====
`ifndef ELINK_CONFIG_SVH
`define ELINK_CONFIG_SVH

// Mesh packet width in bits
`define ELINK_PW 104

// Bytes per packet on the byte link
`define ELINK_NBYTES 13

// Word address width of the external memory, 32-bit words
`define ELINK_MEM_AW 8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the elink loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module elink_loop_tb \
   -o elink_sim \
   && ./obj_dir/elink_sim 2>&1 | tee sim.log \
   || echo "Build or simulation ended with an error"

grep -qx "RESULT: PASS" sim.log 2>/dev/null && echo "Simulation passed" && exit 0
echo "Simulation failed"
exit 1

// ==== src/elink_loop_top.sv ====
`timescale 1ns/1ps

module elink_loop_top
   import elink_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          ext_access,          // Host request strobe
   input  emesh_packet_t ext_packet,
   output logic          rd_wait,             // Read lane busy
   output logic          wr_wait,             // Write lane busy
   input  logic          ext_rr_wait,         // Host back-pressure on responses
   output logic          dut_access,          // Response valid
   output emesh_packet_t dut_packet
);

   link_byte_t    wr_link;                    // Write lane byte link
   link_byte_t    rd_link;                    // Read lane byte link
   logic          wr_hold;
   logic          rd_hold;
   logic          wr_valid;                   // Rebuilt write ready
   logic          rd_valid;                   // Rebuilt read ready
   emesh_packet_t wr_packet;
   emesh_packet_t rd_packet;
   logic          emem_rd_wait;               // Port stalls read receiver

   // Write lane
   lane_tx #(
      .KIND       (LANE_WRITE)
   ) wr_tx (
      .clkin      (clkin),
      .reset      (reset),
      .ext_access (ext_access),
      .ext_packet (ext_packet),
      .lane_wait  (wr_wait),
      .link_hold  (wr_hold),
      .link_out   (wr_link)
   );

   lane_rx wr_rx (
      .clkin      (clkin),
      .reset      (reset),
      .link_in    (wr_link),
      .link_hold  (wr_hold),
      .rx_valid   (wr_valid),
      .rx_packet  (wr_packet),
      .rx_wait    (1'b0)                      // Port never refuses writes
   );

   // Read lane
   lane_tx #(
      .KIND       (LANE_READ)
   ) rd_tx (
      .clkin      (clkin),
      .reset      (reset),
      .ext_access (ext_access),
      .ext_packet (ext_packet),
      .lane_wait  (rd_wait),
      .link_hold  (rd_hold),
      .link_out   (rd_link)
   );

   lane_rx rd_rx (
      .clkin      (clkin),
      .reset      (reset),
      .link_in    (rd_link),
      .link_hold  (rd_hold),
      .rx_valid   (rd_valid),
      .rx_packet  (rd_packet),
      .rx_wait    (emem_rd_wait)
   );

   // Memory and response path
   emem_port emem (
      .clkin      (clkin),
      .reset      (reset),
      .wr_valid   (wr_valid),
      .wr_packet  (wr_packet),
      .rd_valid   (rd_valid),
      .rd_packet  (rd_packet),
      .rd_wait    (emem_rd_wait),
      .rr_wait    (ext_rr_wait),
      .rr_access  (dut_access),
      .rr_packet  (dut_packet)
   );

endmodule

// ==== src/elink_pkg.sv ====
package elink_pkg;

   // Mesh transaction, MSB first
   typedef struct packed {
      logic [31:0] srcaddr;    // Return address for read responses
      logic [31:0] data;       // Write data or read result
      logic [31:0] dstaddr;    // Target address
      logic [3:0]  ctrlmode;   // Passed through untouched
      logic [1:0]  datamode;   // Access size
      logic        write;      // Packet bit 1, selects lane
      logic        spare;      // Bit 0, unused by this link
   } emesh_packet_t;

   // One beat on the byte link
   typedef struct packed {
      logic       frame;       // High on every byte of a packet
      logic [7:0] data;        // Payload byte, LSB of packet first
   } link_byte_t;

   // Lane flavor, value matches the write flag it accepts
   typedef enum logic {
      LANE_READ  = 1'b0,       // Takes write=0 packets
      LANE_WRITE = 1'b1        // Takes write=1 packets
   } lane_kind_t;

   // Transmitter FSM
   typedef enum logic {
      TX_IDLE = 1'b0,          // Waiting for packet or for link
      TX_SEND = 1'b1           // Frame in progress
   } tx_state_t;

endpackage

// ==== src/emem_port.sv ====
`timescale 1ns/1ps
`include "elink_config.svh"

module emem_port
   import elink_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          wr_valid,            // Write lane output
   input  emesh_packet_t wr_packet,
   input  logic          rd_valid,            // Read lane output
   input  emesh_packet_t rd_packet,
   output logic          rd_wait,             // Stalls the read receiver
   input  logic          rr_wait,             // Host not taking responses
   output logic          rr_access,           // Response pending
   output emesh_packet_t rr_packet
);

   localparam int AW = `ELINK_MEM_AW;

   logic [31:0]   mem [2**AW];                // 32-bit word storage
   logic          rd_take;                    // Read accepted this edge
   logic          mem_access;                 // Merged request strobe
   emesh_packet_t mem_packet;                 // Merged request
   logic [AW-1:0] mem_addr;                   // Word index

   // Read blocked by a write this cycle or an unsent response
   assign rd_wait = wr_valid | rr_access;
   assign rd_take = rd_valid & ~rd_wait;

   // Write always wins the merge
   assign mem_access = wr_valid | rd_take;
   assign mem_packet = wr_valid ? wr_packet : rd_packet;
   assign mem_addr   = mem_packet.dstaddr[AW+1:2];

   // Storage write on the valid edge
   always_ff @(posedge clkin) begin
      if (mem_access && mem_packet.write)
         mem[mem_addr] <= mem_packet.data;
   end

   // Response register, payload only
   always_ff @(posedge clkin) begin
      if (rd_take) begin
         rr_packet.srcaddr  <= mem_packet.dstaddr;   // Addresses swap
         rr_packet.data     <= mem[mem_addr];
         rr_packet.dstaddr  <= mem_packet.srcaddr;
         rr_packet.ctrlmode <= mem_packet.ctrlmode;
         rr_packet.datamode <= mem_packet.datamode;
         rr_packet.write    <= 1'b1;                 // Responses travel as writes
         rr_packet.spare    <= 1'b0;
      end
   end

   // Response held until an edge with rr_wait low
   always_ff @(posedge clkin or posedge reset) begin
      if (reset)
         rr_access <= 1'b0;
      else if (rd_take)
         rr_access <= 1'b1;
      else if (!rr_wait)
         rr_access <= 1'b0;
   end

endmodule

// ==== src/lane_rx.sv ====
`timescale 1ns/1ps
`include "elink_config.svh"

module lane_rx
   import elink_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  link_byte_t    link_in,             // Framed bytes from lane_tx
   output logic          link_hold,           // Blocks next frame while full
   output logic          rx_valid,            // Held packet ready
   output emesh_packet_t rx_packet,
   input  logic          rx_wait              // Consumer not ready
);

   localparam int PW = `ELINK_PW;
   localparam int NB = `ELINK_NBYTES;
   localparam int CW = $clog2(NB + 1);

   logic [CW-1:0] cnt_q;                      // Bytes seen in this frame
   logic [PW-9:0] asm_q;                      // First twelve bytes
   logic          valid_q;                    // Output register full
   logic          done;                       // Last byte on the link now
   logic          take;                       // Consumer takes the packet

   assign done = link_in.frame & (cnt_q == CW'(NB - 1));
   assign take = valid_q & ~rx_wait;

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         cnt_q   <= '0;
         valid_q <= 1'b0;
      end else begin
         if (link_in.frame) begin
            if (done)
               cnt_q <= '0;                   // Ready for next frame
            else
               cnt_q <= cnt_q + 1'b1;
         end
         if (done)
            valid_q <= 1'b1;                  // Edge after byte 13
         else if (take)
            valid_q <= 1'b0;
      end
   end

   // Bytes arrive LSB first, shift down from the top
   always_ff @(posedge clkin) begin
      if (link_in.frame && !done)
         asm_q <= {link_in.data, asm_q[PW-9:8]};
      if (done)
         rx_packet <= {link_in.data, asm_q};  // Last byte is the top one
   end

   // Tx never starts while full, so done never hits a full register
   assign link_hold = valid_q;
   assign rx_valid  = valid_q;

endmodule

// ==== src/lane_tx.sv ====
`timescale 1ns/1ps
`include "elink_config.svh"

module lane_tx
   import elink_pkg::*;
#(
   parameter lane_kind_t KIND = LANE_READ     // Which packets this lane takes
) (
   input  logic          clkin,
   input  logic          reset,
   input  logic          ext_access,          // Host strobe, seen by both lanes
   input  emesh_packet_t ext_packet,
   output logic          lane_wait,           // Buffer busy, host holds off
   input  logic          link_hold,           // Receiver full, no new frame
   output link_byte_t    link_out
);

   localparam int PW = `ELINK_PW;
   localparam int NB = `ELINK_NBYTES;
   localparam int CW = $clog2(NB + 1);

   tx_state_t     state_q;
   logic [CW-1:0] cnt_q;                      // Bytes already on the link
   logic          full_q;                     // One packet buffered
   logic          frame_q;                    // Registered frame bit
   logic [7:0]    data_q;                     // Registered link byte
   logic [PW-1:0] shift_q;                    // Packet, next byte at bottom
   logic          kind_flag;                  // Write flag this lane wants
   logic          take;                       // Host packet accepted
   logic          start;                      // First byte goes out
   logic          last;                       // Frame just finished
   logic [PW-1:0] src;                        // Where the first byte comes from

   assign kind_flag = (KIND == LANE_WRITE);

   // Accept only our own kind, and only with a free buffer
   assign take = ext_access & (ext_packet.write == kind_flag) & ~full_q;

   // New frame needs a packet and a free receiver
   assign start = (state_q == TX_IDLE) & (take | full_q) & ~link_hold;

   assign last = (state_q == TX_SEND) & (cnt_q == CW'(NB));

   // Fresh packet bypasses the buffer on a direct start
   assign src = take ? ext_packet : shift_q;

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         state_q <= TX_IDLE;
         cnt_q   <= '0;
         full_q  <= 1'b0;
         frame_q <= 1'b0;
      end else begin
         case (state_q)
            TX_IDLE: begin
               if (take)
                  full_q <= 1'b1;             // Hold host off from this edge
               if (start) begin
                  state_q <= TX_SEND;
                  cnt_q   <= CW'(1);          // Byte 0 leaves now
                  frame_q <= 1'b1;
               end
            end
            TX_SEND: begin
               if (last) begin
                  state_q <= TX_IDLE;
                  cnt_q   <= '0;
                  full_q  <= 1'b0;            // Buffer free after last byte
                  frame_q <= 1'b0;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            default: begin
               state_q <= TX_IDLE;
            end
         endcase
      end
   end

   // Payload path
   always_ff @(posedge clkin) begin
      if (start) begin
         data_q  <= src[7:0];
         shift_q <= {8'h00, src[PW-1:8]};
      end else if (take) begin
         shift_q <= ext_packet;               // Parked until link_hold drops
      end else if ((state_q == TX_SEND) && !last) begin
         data_q  <= shift_q[7:0];
         shift_q <= {8'h00, shift_q[PW-1:8]};
      end
   end

   assign lane_wait      = full_q;
   assign link_out.frame = frame_q;
   assign link_out.data  = data_q;

endmodule
